//--- lc4_processor.f
+incdir+design
design/lc4_isa_pkg.sv
design/lc4_pipe_pkg.sv
design/lc4_fwd_if.sv
design/lc4_regfile.sv
design/lc4_decode_stage.sv
design/lc4_execute_stage.sv
design/lc4_result_stage.sv
design/lc4_processor.sv
test/lc4_processor_sva_chk.sv
test/lc4_trace_monitor.sv
test/lc4_processor_tb.sv

//--- test/lc4_processor_tb.sv
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_processor_tb;

    localparam int         IMEM_SIZE = 1024;
    localparam logic [7:0] WIN_HI    = 8'h40;   // Data memory lives at 16'h40xx

    logic        gwe;
    logic        arst_n;
    logic [15:0] cur_pc;
    logic [15:0] cur_insn;
    logic [15:0] imem_idx;
    logic [15:0] dmem_addr;
    logic [15:0] dmem_rdata;
    logic        dmem_we;
    logic [15:0] dmem_wdata;
    logic        test_stall;
    logic [15:0] test_pc;
    logic [15:0] test_insn;
    logic        test_rf_we;
    logic [2:0]  test_rf_wsel;
    logic [15:0] test_rf_data;
    logic        test_nzp_we;
    logic [2:0]  test_nzp_bits;
    logic        test_dm_we;
    logic [15:0] test_dm_addr;
    logic [15:0] test_dm_data;
    logic [15:0] imem [IMEM_SIZE];
    logic [15:0] dmem [256];
    logic [31:0] rng;
    logic [2:0]  last_rd;          // Destination of the previous generated insn
    int          retired;
    int          errors;
    int          tests_run;
    int          tests_failed;
    bit          aborted;

    initial gwe = 1'b0;
    always #50 gwe = ~gwe;        // 100 ns cycle

    // Combinational instruction and data memories
    assign imem_idx   = cur_pc - `LC4_PC_RESET;
    assign cur_insn   = (imem_idx < IMEM_SIZE) ? imem[imem_idx] : 16'h0000;
    assign dmem_rdata = (dmem_addr[15:8] == WIN_HI) ? dmem[dmem_addr[7:0]] : 16'h0000;

    always @(posedge gwe) begin
        if (dmem_we && dmem_addr[15:8] == WIN_HI)
            dmem[dmem_addr[7:0]] <= dmem_wdata;
    end

    lc4_processor dut0 (
        .gwe (gwe), .i_arst_n (arst_n),
        .o_cur_pc (cur_pc), .i_cur_insn (cur_insn),
        .o_dmem_addr (dmem_addr), .i_cur_dmem_data (dmem_rdata),
        .o_dmem_we (dmem_we), .o_dmem_towrite (dmem_wdata),
        .o_test_stall (test_stall), .o_test_cur_pc (test_pc), .o_test_cur_insn (test_insn),
        .o_test_regfile_we (test_rf_we), .o_test_regfile_wsel (test_rf_wsel),
        .o_test_regfile_data (test_rf_data), .o_test_nzp_we (test_nzp_we),
        .o_test_nzp_new_bits (test_nzp_bits), .o_test_dmem_we (test_dm_we),
        .o_test_dmem_addr (test_dm_addr), .o_test_dmem_data (test_dm_data)
    );

    lc4_trace_monitor monitor0 (
        .gwe (gwe), .i_arst_n (arst_n), .i_cur_pc (cur_pc), .i_cur_insn (cur_insn),
        .i_dmem_we (dmem_we), .i_stall (test_stall), .i_pc (test_pc), .i_insn (test_insn),
        .i_rf_we (test_rf_we), .i_rf_wsel (test_rf_wsel), .i_rf_data (test_rf_data),
        .i_nzp_we (test_nzp_we), .i_nzp_bits (test_nzp_bits), .i_dm_we (test_dm_we),
        .i_dm_addr (test_dm_addr), .i_dm_data (test_dm_data),
        .o_retired (retired), .o_errors (errors)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [15:0] fill_word(input logic [15:0] addr);
        return (addr * 16'h9e37) ^ 16'h5c3d;      // Hash of the full address
    endfunction

    // Mix 0 ALU only, 1 adds stores, 2 adds loads, 3 everything plus NOPs
    function automatic logic [15:0] pick_insn(input int mix);
        logic [31:0] r;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  rt;
        logic [15:0] insn;
        int          kind;
        r    = next_rand();
        rd   = (r[2:0] == 3'd7) ? 3'd0 : r[2:0];     // R7 keeps the data base
        rs   = r[3] ? last_rd : r[6:4];              // Half the sources depend
        rt   = r[7] ? last_rd : r[10:8];
        kind = r[19:16] % 12;
        if (kind >= 9 && mix == 0) kind = kind - 9;
        else if (kind >= 9 && mix == 1) kind = 9;
        else if (kind >= 9 && mix == 2) kind = 10;
        case (kind)
            0:  insn = {4'b0001, rd, rs, 3'b000, rt};          // ADD
            1:  insn = {4'b0001, rd, rs, 3'b010, rt};          // SUB
            2:  insn = {4'b0001, rd, rs, 1'b1, r[24:20]};      // ADD imm5
            3:  insn = {4'b0101, rd, rs, 3'b000, rt};          // AND
            4:  insn = {4'b0101, rd, rs, 3'b001, 3'b000};      // NOT
            5:  insn = {4'b0101, rd, rs, 3'b010, rt};          // OR
            6:  insn = {4'b0101, rd, rs, 3'b011, rt};          // XOR
            7:  insn = {4'b0101, rd, rs, 1'b1, r[24:20]};      // AND imm5
            8:  insn = r[25] ? {4'b1001, rd, r[28:20]} : {4'b1101, rd, 1'b1, r[27:20]};
            9:  insn = {4'b0111, 3'b000, 3'd7, r[22:20], rt};  // STR, Rt sits in imm6
            10: insn = {4'b0110, rd, 3'd7, r[25:20]};          // LDR off R7
            default: insn = {4'b0000, r[11:0]};                // NOP
        endcase
        if (kind <= 8 || kind == 10)
            last_rd = rd;
        return insn;
    endfunction

    task automatic run_test(input string name, input int n_body, input int mix);
        int base_err;
        int cycles;
        int prog_len;
        bit late;
        base_err = errors;
        prog_len = n_body + 2;
        @(negedge gwe);
        arst_n = 1'b0;
        for (int i = 0; i < IMEM_SIZE; i++)
            imem[i] = 16'h0000;
        imem[0] = {4'b1001, 3'd7, 9'h080};           // CONST R7, 0x80
        imem[1] = {4'b1101, 3'd7, 1'b1, 8'h40};      // HICONST R7, 0x40 so R7 = 16'h4080
        last_rd = 3'd0;
        for (int i = 0; i < n_body; i++)
            imem[2 + i] = pick_insn(mix);
        for (int a = 0; a < 256; a++)
            dmem[a] = fill_word({WIN_HI, a[7:0]});
        repeat (2) @(negedge gwe);
        arst_n = 1'b1;
        cycles = 0;
        while (retired < prog_len && cycles < 3 * prog_len + 20) begin
            @(negedge gwe);
            cycles++;
        end
        late = (retired < prog_len);
        if (late) begin
            $display("timeout: %s retired %0d of %0d instructions", name, retired, prog_len);
            aborted = 1'b1;
        end
        tests_run++;
        if (late || errors != base_err)
            tests_failed++;
        $display("%s %0d instructions, %0d cycles, %0d errors%s", name, prog_len, cycles,
                 errors - base_err, late ? ", timed out" : "");
    endtask

    initial begin
        arst_n       = 1'b0;
        rng          = 32'hf3ec_029a;
        last_rd      = 3'd0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        for (int i = 0; i < IMEM_SIZE; i++)
            imem[i] = 16'h0000;
        for (int a = 0; a < 256; a++)
            dmem[a] = 16'h0000;
        run_test("alu_chain", 80, 0);
        if (!aborted) run_test("stores", 80, 1);
        if (!aborted) run_test("loads", 80, 2);
        if (!aborted) run_test("long_run", 398, 3);       // 400 with the base setup
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d", tests_run,
                 tests_failed, errors, dut0.chk0.fails);
        if (tests_failed == 0 && errors == 0 && dut0.chk0.fails == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- test/lc4_trace_monitor.sv
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_trace_monitor (
    input  logic        gwe,
    input  logic        i_arst_n,
    input  logic [15:0] i_cur_pc,       // Fetch side
    input  logic [15:0] i_cur_insn,
    input  logic        i_dmem_we,
    input  logic        i_stall,        // Retire trace from here on
    input  logic [15:0] i_pc,
    input  logic [15:0] i_insn,
    input  logic        i_rf_we,
    input  logic [2:0]  i_rf_wsel,
    input  logic [15:0] i_rf_data,
    input  logic        i_nzp_we,
    input  logic [2:0]  i_nzp_bits,
    input  logic        i_dm_we,
    input  logic [15:0] i_dm_addr,
    input  logic [15:0] i_dm_data,
    output int          o_retired,
    output int          o_errors
);

    localparam int         PROG_SIZE = 1024;
    localparam logic [7:0] WIN_HI    = 8'h40;   // Data window 16'h4000 to 16'h40ff

    logic [15:0] regs [8];
    logic [15:0] mem [256];
    logic [15:0] fetched [PROG_SIZE];    // Word returned at each fetched PC
    logic        seen [PROG_SIZE];
    logic [15:0] exp_pc;
    logic [15:0] fetch_idx;
    logic        reset_held = 1'b0;      // Reset also low at the previous edge
    int          retired;
    int          errors;

    assign o_retired = retired;
    assign o_errors  = errors;

    // Same address hash as the data memory of the testbench
    function automatic logic [15:0] fill_word(input logic [15:0] addr);
        return (addr * 16'h9e37) ^ 16'h5c3d;
    endfunction

    task automatic report_mismatch(input string sig, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("mismatch %s at pc %h: got %h expected %h", sig, exp_pc, got, exp);
        errors++;
    endtask

    task automatic report_fault(input string what);
        $display("error at pc %h: %s", exp_pc, what);
        errors++;
    endtask

    task automatic restart_model();
        for (int i = 0; i < 8; i++)
            regs[i] = 16'h0000;
        for (int a = 0; a < 256; a++)
            mem[a] = fill_word({WIN_HI, a[7:0]});
        for (int i = 0; i < PROG_SIZE; i++)
            seen[i] = 1'b0;
        exp_pc  = `LC4_PC_RESET;
        retired = 0;
    endtask

    // One instruction of the ISA, then compare with what writeback shows
    task automatic check_retire();
        logic [15:0] idx;
        logic [15:0] insn;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] val;
        logic [15:0] addr;
        logic        we;
        logic        dwe;
        idx = exp_pc - `LC4_PC_RESET;
        insn = 16'h0000;
        if (idx >= PROG_SIZE || !seen[idx])
            report_fault("retired a PC that was never fetched");
        else
            insn = fetched[idx];
        if (i_pc !== exp_pc) report_mismatch("o_test_cur_pc", i_pc, exp_pc);
        if (i_insn !== insn) report_mismatch("o_test_cur_insn", i_insn, insn);
        a    = regs[insn[8:6]];                      // Rs
        b    = regs[insn[2:0]];                      // Rt
        addr = a + {{10{insn[5]}}, insn[5:0]};
        val  = 16'h0000;
        we   = 1'b1;
        dwe  = 1'b0;
        case (insn[15:12])
            4'b0001: begin
                if (insn[5])                 val = a + {{11{insn[4]}}, insn[4:0]};
                else if (insn[5:3] == 3'b000) val = a + b;
                else if (insn[5:3] == 3'b010) val = a - b;
                else                          we = 1'b0;     // MUL, DIV unused
            end
            4'b0101: begin
                if (insn[5])                 val = a & {{11{insn[4]}}, insn[4:0]};
                else if (insn[4:3] == 2'b00) val = a & b;
                else if (insn[4:3] == 2'b01) val = ~a;
                else if (insn[4:3] == 2'b10) val = a | b;
                else                         val = a ^ b;
            end
            4'b1001: val = {{7{insn[8]}}, insn[8:0]};
            4'b1101: val = {insn[7:0], regs[insn[11:9]][7:0]};
            4'b0110: val = mem[addr[7:0]];
            4'b0111: begin
                we  = 1'b0;
                dwe = 1'b1;
            end
            default: we = 1'b0;                              // NOP
        endcase
        if (i_rf_we !== we)   report_mismatch("o_test_regfile_we", i_rf_we, we);
        if (i_nzp_we !== we)  report_mismatch("o_test_nzp_we", i_nzp_we, we);
        if (i_dm_we !== dwe)  report_mismatch("o_test_dmem_we", i_dm_we, dwe);
        if (we) begin
            if (i_rf_wsel !== insn[11:9])
                report_mismatch("o_test_regfile_wsel", i_rf_wsel, insn[11:9]);
            if (i_rf_data !== val) report_mismatch("o_test_regfile_data", i_rf_data, val);
            if (i_nzp_bits !== {val[15], val == 16'h0, !val[15] && val != 16'h0})
                report_mismatch("o_test_nzp_new_bits", i_nzp_bits,
                                {val[15], val == 16'h0, !val[15] && val != 16'h0});
            regs[insn[11:9]] = val;
        end
        if (insn[15:13] == 3'b011) begin                     // LDR or STR
            if (i_dm_addr !== addr) report_mismatch("o_test_dmem_addr", i_dm_addr, addr);
            if (i_dm_data !== (dwe ? b : val))
                report_mismatch("o_test_dmem_data", i_dm_data, dwe ? b : val);
        end
        if (dwe)
            mem[addr[7:0]] = b;
        exp_pc++;
        retired++;
    endtask

    // Pre-edge values, the DUT updates after this in the same step
    always @(posedge gwe) begin
        if (!i_arst_n) begin
            restart_model();
            if (reset_held && (i_stall !== 1'b1 || i_rf_we !== 1'b0 ||
                               i_nzp_we !== 1'b0 || i_dm_we !== 1'b0 ||
                               i_dmem_we !== 1'b0))
                report_fault("trace not idle while reset is held");
            reset_held = 1'b1;
        end else begin
            reset_held = 1'b0;
            fetch_idx = i_cur_pc - `LC4_PC_RESET;
            if (fetch_idx < PROG_SIZE) begin
                fetched[fetch_idx] = i_cur_insn;
                seen[fetch_idx]    = 1'b1;
            end
            if (i_stall) begin
                if (i_rf_we !== 1'b0 || i_nzp_we !== 1'b0 || i_dm_we !== 1'b0)
                    report_fault("write enable high during a stall");
            end else begin
                check_retire();
            end
        end
    end

endmodule

//--- test/lc4_processor_sva_chk.sv
`timescale 1ns/1ps

module lc4_processor_sva_chk (
    input  logic        gwe,
    input  logic        i_arst_n,
    input  logic [15:0] i_cur_pc,
    input  logic        i_dmem_we,
    input  logic        i_stall,        // Writeback holds a bubble
    input  logic        i_rf_we,
    input  logic        i_nzp_we,
    input  logic        i_dm_we
);

    int fails = 0;                      // Count of failed assertions

    // A bubble in writeback retires nothing
    no_write_in_stall: assert property (@(posedge gwe) disable iff (!i_arst_n)
        i_stall |-> !(i_rf_we || i_nzp_we || i_dm_we))
        else begin
            $error("write enable high while the trace shows a stall");
            fails++;
        end

    dmem_we_known: assert property (@(posedge gwe) disable iff (!i_arst_n)
        !$isunknown(i_dmem_we))
        else begin
            $error("o_dmem_we is unknown");
            fails++;
        end

    // Fetch only holds on a load-use stall or steps to the next word
    pc_step: assert property (@(posedge gwe) disable iff (!i_arst_n)
        (i_cur_pc == $past(i_cur_pc)) || (i_cur_pc == $past(i_cur_pc) + 16'd1))
        else begin
            $error("o_cur_pc neither held nor advanced by one");
            fails++;
        end

endmodule

bind lc4_processor lc4_processor_sva_chk chk0 (
    .gwe       (gwe),
    .i_arst_n  (i_arst_n),
    .i_cur_pc  (o_cur_pc),
    .i_dmem_we (o_dmem_we),
    .i_stall   (o_test_stall),
    .i_rf_we   (o_test_regfile_we),
    .i_nzp_we  (o_test_nzp_we),
    .i_dm_we   (o_test_dmem_we)
);

//--- design/lc4_processor.sv
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_processor (
    input  logic                  gwe,
    input  logic                  i_arst_n,
    output logic [`LC4_WORD-1:0]  o_cur_pc,             // Instruction memory address
    input  logic [`LC4_WORD-1:0]  i_cur_insn,
    output logic [`LC4_WORD-1:0]  o_dmem_addr,
    input  logic [`LC4_WORD-1:0]  i_cur_dmem_data,
    output logic                  o_dmem_we,
    output logic [`LC4_WORD-1:0]  o_dmem_towrite,
    output logic                  o_test_stall,         // Bubble in writeback
    output logic [`LC4_WORD-1:0]  o_test_cur_pc,
    output logic [`LC4_WORD-1:0]  o_test_cur_insn,
    output logic                  o_test_regfile_we,
    output logic [`LC4_REG_W-1:0] o_test_regfile_wsel,
    output logic [`LC4_WORD-1:0]  o_test_regfile_data,
    output logic                  o_test_nzp_we,
    output logic [2:0]            o_test_nzp_new_bits,
    output logic                  o_test_dmem_we,
    output logic [`LC4_WORD-1:0]  o_test_dmem_addr,
    output logic [`LC4_WORD-1:0]  o_test_dmem_data
);

    lc4_pipe_pkg::dx_t     dx;
    lc4_pipe_pkg::xm_t     xm;
    lc4_pipe_pkg::mw_t     mw;
    logic                  x_load_valid;
    logic [`LC4_REG_W-1:0] x_wsel;

    lc4_fwd_if fwd ();

    lc4_decode_stage decode0 (
        .gwe            (gwe),
        .i_arst_n       (i_arst_n),
        .i_cur_insn     (i_cur_insn),
        .i_x_load_valid (x_load_valid),
        .i_x_wsel       (x_wsel),
        .fwd            (fwd.rf),
        .o_cur_pc       (o_cur_pc),
        .o_dx           (dx)
    );

    lc4_execute_stage execute0 (
        .gwe            (gwe),
        .i_arst_n       (i_arst_n),
        .i_dx           (dx),
        .fwd            (fwd.exe),
        .o_xm           (xm),
        .o_x_load_valid (x_load_valid),
        .o_x_wsel       (x_wsel)
    );

    lc4_result_stage result0 (
        .gwe             (gwe),
        .i_arst_n        (i_arst_n),
        .i_xm            (xm),
        .i_cur_dmem_data (i_cur_dmem_data),
        .fwd             (fwd.src),
        .o_dmem_addr     (o_dmem_addr),
        .o_dmem_we       (o_dmem_we),
        .o_dmem_towrite  (o_dmem_towrite),
        .o_mw            (mw)
    );

    // Retire trace straight from the writeback register
    assign o_test_stall        = !mw.valid;
    assign o_test_cur_pc       = mw.pc;
    assign o_test_cur_insn     = mw.insn;
    assign o_test_regfile_we   = mw.valid && mw.regfile_we;
    assign o_test_regfile_wsel = mw.wsel;
    assign o_test_regfile_data = mw.data;
    assign o_test_nzp_we       = o_test_regfile_we;     // Every register write sets NZP
    assign o_test_nzp_new_bits = mw.nzp;
    assign o_test_dmem_we      = mw.valid && mw.dmem_we;
    assign o_test_dmem_addr    = mw.dmem_addr;
    assign o_test_dmem_data    = mw.dmem_data;

endmodule

//--- design/lc4_result_stage.sv
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_result_stage (
    input  logic                 gwe,
    input  logic                 i_arst_n,
    input  lc4_pipe_pkg::xm_t    i_xm,
    input  logic [`LC4_WORD-1:0] i_cur_dmem_data,   // Combinational read data
    lc4_fwd_if.src               fwd,
    output logic [`LC4_WORD-1:0] o_dmem_addr,
    output logic                 o_dmem_we,
    output logic [`LC4_WORD-1:0] o_dmem_towrite,
    output lc4_pipe_pkg::mw_t    o_mw
);

    lc4_pipe_pkg::xm_t    m_q;
    lc4_pipe_pkg::mw_t    mw_d;
    lc4_pipe_pkg::mw_t    w_q;
    logic [`LC4_WORD-1:0] m_value;  // Value the memory-stage insn will write

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            m_q <= '0;
            w_q <= '0;
        end else begin
            m_q <= i_xm;
            w_q <= mw_d;
        end
    end

    // Data memory access
    assign o_dmem_we      = m_q.valid && m_q.is_store;
    assign o_dmem_addr    = (m_q.is_load || m_q.is_store) ? m_q.result : '0;
    assign o_dmem_towrite = o_dmem_we ? m_q.store_data : '0;
    assign m_value        = m_q.is_load ? i_cur_dmem_data : m_q.result;

    always_comb begin
        mw_d.valid      = m_q.valid;
        mw_d.pc         = m_q.pc;
        mw_d.insn       = m_q.insn;
        mw_d.wsel       = m_q.wsel;
        mw_d.regfile_we = m_q.regfile_we;
        mw_d.data       = m_value;
        mw_d.nzp        = lc4_isa_pkg::nzp_of(m_value);
        mw_d.dmem_we    = o_dmem_we;
        mw_d.dmem_addr  = o_dmem_addr;
        mw_d.dmem_data  = m_q.is_load ? i_cur_dmem_data : o_dmem_towrite;
    end

    // Bypass sources and the register write
    assign fwd.m_we   = m_q.valid && m_q.regfile_we;
    assign fwd.m_wsel = m_q.wsel;
    assign fwd.m_data = m_value;
    assign fwd.w_we   = w_q.valid && w_q.regfile_we;
    assign fwd.w_wsel = w_q.wsel;
    assign fwd.w_data = w_q.data;

    assign o_mw = w_q;

endmodule

//--- design/lc4_execute_stage.sv
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_execute_stage (
    input  logic                  gwe,
    input  logic                  i_arst_n,
    input  lc4_pipe_pkg::dx_t     i_dx,
    lc4_fwd_if.exe                fwd,
    output lc4_pipe_pkg::xm_t     o_xm,
    output logic                  o_x_load_valid,
    output logic [`LC4_REG_W-1:0] o_x_wsel
);

    lc4_pipe_pkg::dx_t    x_q;
    logic [`LC4_WORD-1:0] op_a;     // Forwarded Rs (Rd for HICONST)
    logic [`LC4_WORD-1:0] op_b;     // Forwarded Rt
    logic [`LC4_WORD-1:0] alu_b;
    logic [`LC4_WORD-1:0] alu_y;

    // Newest producer wins: memory, then writeback, then register data
    function automatic logic [`LC4_WORD-1:0] bypass(
        input logic [`LC4_REG_W-1:0] sel,
        input logic [`LC4_WORD-1:0]  rf_data
    );
        if (fwd.m_we && fwd.m_wsel == sel)
            return fwd.m_data;
        if (fwd.w_we && fwd.w_wsel == sel)
            return fwd.w_data;
        return rf_data;
    endfunction

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n)
            x_q <= '0;
        else
            x_q <= i_dx;
    end

    always_comb begin
        op_a = bypass(x_q.r1sel, x_q.r1data);
        op_b = bypass(x_q.r2sel, x_q.r2data);
    end

    // AND imm5 shares the AND path with the immediate in place of Rt
    assign alu_b = (x_q.alu_op == lc4_isa_pkg::ALU_AND && x_q.insn[`LC4_IMM_BIT]) ?
                   x_q.imm : op_b;

    always_comb begin
        case (x_q.alu_op)
            lc4_isa_pkg::ALU_ADD:     alu_y = op_a + alu_b;
            lc4_isa_pkg::ALU_SUB:     alu_y = op_a - alu_b;
            lc4_isa_pkg::ALU_AND:     alu_y = op_a & alu_b;
            lc4_isa_pkg::ALU_NOT:     alu_y = ~op_a;
            lc4_isa_pkg::ALU_OR:      alu_y = op_a | alu_b;
            lc4_isa_pkg::ALU_XOR:     alu_y = op_a ^ alu_b;
            lc4_isa_pkg::ALU_CONST:   alu_y = x_q.imm;
            lc4_isa_pkg::ALU_HICONST: alu_y = {x_q.imm[7:0], op_a[7:0]};
            lc4_isa_pkg::ALU_ADDR:    alu_y = op_a + x_q.imm;   // Also LDR/STR address
            default:                  alu_y = '0;
        endcase
    end

    always_comb begin
        o_xm.valid      = x_q.valid;
        o_xm.pc         = x_q.pc;
        o_xm.insn       = x_q.insn;
        o_xm.wsel       = x_q.wsel;
        o_xm.regfile_we = x_q.regfile_we;
        o_xm.is_load    = x_q.is_load;
        o_xm.is_store   = x_q.is_store;
        o_xm.result     = alu_y;
        o_xm.store_data = op_b;         // Rt after bypass
    end

    // Load destination back to decode for the hazard check
    assign o_x_load_valid = x_q.valid && x_q.is_load;
    assign o_x_wsel       = x_q.wsel;

endmodule

//--- design/lc4_decode_stage.sv
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_decode_stage (
    input  logic                  gwe,
    input  logic                  i_arst_n,
    input  logic [`LC4_WORD-1:0]  i_cur_insn,
    input  logic                  i_x_load_valid,  // Load sitting in execute
    input  logic [`LC4_REG_W-1:0] i_x_wsel,        // Its destination
    lc4_fwd_if.rf                 fwd,
    output logic [`LC4_WORD-1:0]  o_cur_pc,
    output lc4_pipe_pkg::dx_t     o_dx
);

    logic [`LC4_WORD-1:0]  pc_q;
    logic [`LC4_WORD-1:0]  d_pc;
    logic [`LC4_WORD-1:0]  d_insn;
    logic                  d_valid;
    logic [2:0]            sub;                 // Sub-op of register forms
    logic                  r1re;
    logic                  r2re;
    logic                  stall;
    logic [`LC4_WORD-1:0]  r1data;
    logic [`LC4_WORD-1:0]  r2data;
    lc4_pipe_pkg::dx_t     dx;                  // Decoded, before the bubble gate

    // Fetch PC and fetch/decode register both hold on a load-use stall
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q    <= `LC4_PC_RESET;
            d_valid <= 1'b0;
            d_pc    <= '0;
            d_insn  <= '0;
        end else if (!stall) begin
            pc_q    <= pc_q + 1'b1;
            d_valid <= 1'b1;
            d_pc    <= pc_q;
            d_insn  <= i_cur_insn;
        end
    end

    assign o_cur_pc = pc_q;
    assign sub      = d_insn[`LC4_SUB_HI:`LC4_SUB_LO];

    always_comb begin
        dx        = '0;
        dx.pc     = d_pc;
        dx.insn   = d_insn;
        dx.r1sel  = d_insn[`LC4_RS_HI:`LC4_RS_LO];
        dx.r2sel  = d_insn[`LC4_RT_HI:`LC4_RT_LO];
        dx.wsel   = d_insn[`LC4_RD_HI:`LC4_RD_LO];
        dx.alu_op = lc4_isa_pkg::ALU_ADD;
        dx.imm    = {{(`LC4_WORD-5){d_insn[4]}}, d_insn[4:0]};    // imm5 unless changed
        r1re      = 1'b0;
        r2re      = 1'b0;
        case (lc4_isa_pkg::opcode_e'(d_insn[`LC4_OP_HI:`LC4_OP_LO]))
            lc4_isa_pkg::OP_ARITH: begin
                r1re = 1'b1;
                if (d_insn[`LC4_IMM_BIT]) begin
                    dx.alu_op     = lc4_isa_pkg::ALU_ADDR;   // Rs + imm5
                    dx.regfile_we = 1'b1;
                end else if (sub == 3'b000 || sub == 3'b010) begin
                    r2re          = 1'b1;
                    dx.alu_op     = sub[1] ? lc4_isa_pkg::ALU_SUB : lc4_isa_pkg::ALU_ADD;
                    dx.regfile_we = 1'b1;
                end                                          // MUL and DIV stay NOP
            end
            lc4_isa_pkg::OP_LOGIC: begin
                r1re          = 1'b1;
                dx.regfile_we = 1'b1;
                if (d_insn[`LC4_IMM_BIT]) begin
                    dx.alu_op = lc4_isa_pkg::ALU_AND;        // Execute picks imm as b
                end else begin
                    r2re = (sub[1:0] != 2'b01);              // NOT has one source
                    case (sub[1:0])
                        2'b00:   dx.alu_op = lc4_isa_pkg::ALU_AND;
                        2'b01:   dx.alu_op = lc4_isa_pkg::ALU_NOT;
                        2'b10:   dx.alu_op = lc4_isa_pkg::ALU_OR;
                        default: dx.alu_op = lc4_isa_pkg::ALU_XOR;
                    endcase
                end
            end
            lc4_isa_pkg::OP_CONST: begin
                dx.alu_op     = lc4_isa_pkg::ALU_CONST;
                dx.imm        = {{(`LC4_WORD-9){d_insn[8]}}, d_insn[8:0]};
                dx.regfile_we = 1'b1;
            end
            lc4_isa_pkg::OP_HICONST: begin
                r1re          = 1'b1;
                dx.r1sel      = d_insn[`LC4_RD_HI:`LC4_RD_LO];   // Keeps the low byte of Rd
                dx.alu_op     = lc4_isa_pkg::ALU_HICONST;
                dx.imm        = {8'h00, d_insn[7:0]};
                dx.regfile_we = 1'b1;
            end
            lc4_isa_pkg::OP_LDR, lc4_isa_pkg::OP_STR: begin
                r1re          = 1'b1;
                dx.alu_op     = lc4_isa_pkg::ALU_ADDR;
                dx.imm        = {{(`LC4_WORD-6){d_insn[5]}}, d_insn[5:0]};
                dx.is_load    = !d_insn[12];
                dx.is_store   = d_insn[12];
                dx.regfile_we = !d_insn[12];
                r2re          = d_insn[12];                  // STR reads Rt
            end
            default: ;
        endcase
    end

    // Load-use hazard, one bubble
    assign stall = d_valid && i_x_load_valid &&
                   ((r1re && dx.r1sel == i_x_wsel) || (r2re && dx.r2sel == i_x_wsel));

    lc4_regfile regfile0 (
        .gwe      (gwe),
        .i_arst_n (i_arst_n),
        .i_r1sel  (dx.r1sel),
        .i_r2sel  (dx.r2sel),
        .fwd      (fwd),
        .o_r1data (r1data),
        .o_r2data (r2data)
    );

    always_comb begin
        o_dx            = dx;
        o_dx.valid      = d_valid && !stall;
        o_dx.regfile_we = dx.regfile_we && o_dx.valid;   // Bubbles write nothing
        o_dx.is_load    = dx.is_load && o_dx.valid;
        o_dx.is_store   = dx.is_store && o_dx.valid;
        o_dx.r1data     = r1data;
        o_dx.r2data     = r2data;
    end

endmodule

//--- design/lc4_regfile.sv
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_regfile (
    input  logic                  gwe,
    input  logic                  i_arst_n,
    input  logic [`LC4_REG_W-1:0] i_r1sel,
    input  logic [`LC4_REG_W-1:0] i_r2sel,
    lc4_fwd_if.rf                 fwd,
    output logic [`LC4_WORD-1:0]  o_r1data,
    output logic [`LC4_WORD-1:0]  o_r2data
);

    logic [`LC4_WORD-1:0] regs [`LC4_NREGS];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `LC4_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (fwd.w_we) begin
            regs[fwd.w_wsel] <= fwd.w_data;    // Writeback result
        end
    end

    // Same-cycle write passes straight to the reads
    assign o_r1data = (fwd.w_we && fwd.w_wsel == i_r1sel) ? fwd.w_data : regs[i_r1sel];
    assign o_r2data = (fwd.w_we && fwd.w_wsel == i_r2sel) ? fwd.w_data : regs[i_r2sel];

endmodule

//--- design/lc4_fwd_if.sv
`timescale 1ns/1ps
`include "lc4_macros.svh"

// Results of the memory and writeback stages, for bypass and register write
interface lc4_fwd_if;

    logic                  m_we;     // Instruction in memory writes a register
    logic [`LC4_REG_W-1:0] m_wsel;
    logic [`LC4_WORD-1:0]  m_data;   // Load data for a load
    logic                  w_we;     // Register write this cycle
    logic [`LC4_REG_W-1:0] w_wsel;
    logic [`LC4_WORD-1:0]  w_data;

    modport src (output m_we, m_wsel, m_data, w_we, w_wsel, w_data);

    modport exe (input m_we, m_wsel, m_data, w_we, w_wsel, w_data);

    modport rf (input w_we, w_wsel, w_data);

endinterface

//--- design/lc4_pipe_pkg.sv
`include "lc4_macros.svh"

package lc4_pipe_pkg;

    // Decode to execute
    typedef struct packed {
        logic                    valid;
        logic [`LC4_WORD-1:0]    pc;
        logic [`LC4_WORD-1:0]    insn;
        lc4_isa_pkg::alu_op_e    alu_op;
        logic [`LC4_REG_W-1:0]   r1sel;
        logic [`LC4_REG_W-1:0]   r2sel;
        logic [`LC4_REG_W-1:0]   wsel;
        logic                    regfile_we;
        logic                    is_load;
        logic                    is_store;
        logic [`LC4_WORD-1:0]    imm;        // Already sign-extended
        logic [`LC4_WORD-1:0]    r1data;
        logic [`LC4_WORD-1:0]    r2data;
    } dx_t;

    // Execute to memory
    typedef struct packed {
        logic                    valid;
        logic [`LC4_WORD-1:0]    pc;
        logic [`LC4_WORD-1:0]    insn;
        logic [`LC4_REG_W-1:0]   wsel;
        logic                    regfile_we;
        logic                    is_load;
        logic                    is_store;
        logic [`LC4_WORD-1:0]    result;     // ALU value or memory address
        logic [`LC4_WORD-1:0]    store_data;
    } xm_t;

    // Memory to writeback, also the retire trace
    typedef struct packed {
        logic                    valid;
        logic [`LC4_WORD-1:0]    pc;
        logic [`LC4_WORD-1:0]    insn;
        logic [`LC4_REG_W-1:0]   wsel;
        logic                    regfile_we;
        logic [`LC4_WORD-1:0]    data;
        lc4_isa_pkg::nzp_t       nzp;
        logic                    dmem_we;
        logic [`LC4_WORD-1:0]    dmem_addr;
        logic [`LC4_WORD-1:0]    dmem_data;  // Loaded or stored word
    } mw_t;

endpackage

//--- design/lc4_isa_pkg.sv
`include "lc4_macros.svh"

package lc4_isa_pkg;

    // Opcodes this core executes, anything else retires as a NOP
    typedef enum logic [3:0] {
        OP_NOP     = 4'b0000,
        OP_ARITH   = 4'b0001,   // ADD, SUB, ADD imm5
        OP_LOGIC   = 4'b0101,   // AND, NOT, OR, XOR, AND imm5
        OP_LDR     = 4'b0110,
        OP_STR     = 4'b0111,
        OP_CONST   = 4'b1001,
        OP_HICONST = 4'b1101
    } opcode_e;

    // What execute does with its operands
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_NOT,
        ALU_OR,
        ALU_XOR,
        ALU_CONST,              // Sign-extended imm9
        ALU_HICONST,            // imm8 over the low byte of Rd
        ALU_ADDR                // Rs plus immediate, also ADD imm5
    } alu_op_e;

    typedef struct packed {
        logic n;
        logic z;
        logic p;
    } nzp_t;

    // Condition bits of a value written to the register file
    function automatic nzp_t nzp_of(input logic [`LC4_WORD-1:0] value);
        nzp_t bits;
        bits.n = value[`LC4_WORD-1];
        bits.z = (value == '0);
        bits.p = !bits.n && !bits.z;
        return bits;
    endfunction

endpackage

//--- design/lc4_macros.svh
`ifndef LC4_MACROS_SVH
`define LC4_MACROS_SVH

// Datapath and register file sizes
`define LC4_WORD     16
`define LC4_REG_W    3
`define LC4_NREGS    8
`define LC4_PC_RESET 16'h8200   // First fetch address after reset

// Instruction field positions
`define LC4_OP_HI    15
`define LC4_OP_LO    12
`define LC4_RD_HI    11
`define LC4_RD_LO    9
`define LC4_RS_HI    8
`define LC4_RS_LO    6
`define LC4_RT_HI    2
`define LC4_RT_LO    0
`define LC4_IMM_BIT  5          // Set for the imm5 forms of arith and logic
`define LC4_SUB_HI   5          // Sub-op of the register forms
`define LC4_SUB_LO   3

`endif
